// File: mips_pkg.sv
// MIPS execute definitions
`default_nettype none

package mips_pkg;

  // data word and register number
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;

  // ALU operation codes
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_AND  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_XOR  = 4'd4;
  localparam alu_op_t ALU_NOR  = 4'd5;
  localparam alu_op_t ALU_SLT  = 4'd6;
  localparam alu_op_t ALU_SLTU = 4'd7;
  // passes the already shifted immediate through
  localparam alu_op_t ALU_LUI  = 4'd8;

  // primary opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_SLTI  = 6'h0a;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_LUI   = 6'h0f;

  // R-type funct field, instr[5:0]
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_XOR  = 6'h26;
  localparam logic [5:0] FN_NOR  = 6'h27;
  localparam logic [5:0] FN_SLT  = 6'h2a;
  localparam logic [5:0] FN_SLTU = 6'h2b;

  // decoder output, consumed by register file and ALU
  typedef struct packed {
    logic      valid;
    // low when the destination is $zero
    logic      write_en;
    alu_op_t   alu_op;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    logic      use_imm;
    // sign, zero or upper-half extended already
    word_t     imm;
  } decoded_op_t;

  // one register write, used for the write port and the wb output
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    word_t     data;
  } wb_t;

endpackage

`default_nettype wire

// File: instr_decode.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input  logic                  instr_valid,
  input  mips_pkg::word_t       instr,
  output mips_pkg::decoded_op_t decoded_op,
  output logic                  illegal
);

  import mips_pkg::*;

  // instruction fields
  logic [5:0]  opcode;
  logic [5:0]  funct;
  reg_addr_t   f_rs;
  reg_addr_t   f_rt;
  reg_addr_t   f_rd;
  logic [15:0] imm16;

  // per-opcode decode results
  logic      legal;
  alu_op_t   alu_op;
  reg_addr_t dest;
  logic      use_imm;
  word_t     imm;

  assign opcode = instr[31:26];
  assign f_rs   = instr[25:21];
  assign f_rt   = instr[20:16];
  assign f_rd   = instr[15:11];
  assign funct  = instr[5:0];
  assign imm16  = instr[15:0];

  always_comb begin
    // I-type defaults, rt is the destination
    legal   = 1'b1;
    alu_op  = ALU_ADD;
    dest    = f_rt;
    use_imm = 1'b1;
    imm     = '0;

    case (opcode)
      OP_RTYPE: begin
        dest    = f_rd;
        use_imm = 1'b0;
        case (funct)
          FN_ADDU: alu_op = ALU_ADD;
          FN_SUBU: alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_NOR:  alu_op = ALU_NOR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLTU: alu_op = ALU_SLTU;
          default: legal  = 1'b0;
        endcase
      end
      OP_ADDIU: begin
        alu_op = ALU_ADD;
        imm    = {{16{imm16[15]}}, imm16};
      end
      OP_SLTI: begin
        alu_op = ALU_SLT;
        imm    = {{16{imm16[15]}}, imm16};
      end
      // logical immediates are zero extended
      OP_ANDI: begin
        alu_op = ALU_AND;
        imm    = {16'h0000, imm16};
      end
      OP_ORI: begin
        alu_op = ALU_OR;
        imm    = {16'h0000, imm16};
      end
      OP_XORI: begin
        alu_op = ALU_XOR;
        imm    = {16'h0000, imm16};
      end
      OP_LUI: begin
        alu_op = ALU_LUI;
        imm    = {imm16, 16'h0000};
      end
      default: legal = 1'b0;
    endcase
  end

  assign decoded_op.valid    = instr_valid & legal;
  assign decoded_op.write_en = (dest != '0);
  assign decoded_op.alu_op   = alu_op;
  assign decoded_op.rs       = f_rs;
  assign decoded_op.rt       = f_rt;
  assign decoded_op.dest     = dest;
  assign decoded_op.use_imm  = use_imm;
  assign decoded_op.imm      = imm;

  // only strobed words can be flagged
  assign illegal = instr_valid & ~legal;

endmodule

`default_nettype wire

// File: regfile.sv
// Integer register file
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic              clk,
  input  logic              reset,
  input  mips_pkg::reg_addr_t ra1,
  input  mips_pkg::reg_addr_t ra2,
  input  mips_pkg::wb_t     wr,
  output mips_pkg::word_t   rd1,
  output mips_pkg::word_t   rd2,
  output mips_pkg::word_t   reg_v0
);

  import mips_pkg::*;

  // $v0 lives at index 2
  localparam reg_addr_t V0_ADDR = 5'd2;

  word_t rf [32];

  // one write port, data lands on the rising edge
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        rf[i] <= '0;
      end
    end else if (wr.valid) begin
      rf[wr.addr] <= wr.data;
    end
  end

  // two combinational read ports
  // $zero reads as zero whatever the array holds
  assign rd1 = (ra1 != '0) ? rf[ra1] : '0;
  assign rd2 = (ra2 != '0) ? rf[ra2] : '0;

  // plain tap on the stored $v0
  assign reg_v0 = rf[V0_ADDR];

  // decoder must have suppressed writes to $zero before they get here
  a_no_zero_write : assert property (
    @(posedge clk) disable iff (reset)
    wr.valid |-> (wr.addr != '0)
  ) else $error("write port targeted register 0");

endmodule

`default_nettype wire

// File: alu_writeback.sv
// ALU and write-back stage
`timescale 1ns/1ps
`default_nettype none

module alu_writeback (
  input  logic                  clk,
  input  logic                  reset,
  input  mips_pkg::decoded_op_t op,
  input  logic                  illegal_in,
  input  mips_pkg::word_t       rd1,
  input  mips_pkg::word_t       rd2,
  output mips_pkg::wb_t         wr,
  output mips_pkg::wb_t         wb,
  output logic                  illegal
);

  import mips_pkg::*;

  word_t src_a;
  word_t src_b;
  word_t result;

  assign src_a = rd1;
  // immediate replaces rt for I-type words
  assign src_b = op.use_imm ? op.imm : rd2;

  always_comb begin
    case (op.alu_op)
      ALU_ADD:  result = src_a + src_b;
      ALU_SUB:  result = src_a - src_b;
      ALU_AND:  result = src_a & src_b;
      ALU_OR:   result = src_a | src_b;
      ALU_XOR:  result = src_a ^ src_b;
      ALU_NOR:  result = ~(src_a | src_b);
      ALU_SLT:  result = {31'd0, $signed(src_a) < $signed(src_b)};
      ALU_SLTU: result = {31'd0, src_a < src_b};
      ALU_LUI:  result = src_b;
      default:  result = '0;
    endcase
  end

  // write port record, same cycle as the strobe
  assign wr.valid = op.valid & op.write_en;
  assign wr.addr  = op.dest;
  assign wr.data  = result;

  // control flags are reset, the payload just follows
  always_ff @(posedge clk) begin
    if (reset) begin
      wb.valid <= 1'b0;
      illegal  <= 1'b0;
    end else begin
      wb.valid <= wr.valid;
      illegal  <= illegal_in;
    end
    wb.addr <= wr.addr;
    wb.data <= wr.data;
  end

  // a cycle carries either a write-back or an illegal pulse
  a_illegal_no_wb : assert property (
    @(posedge clk) disable iff (reset)
    !(wb.valid && illegal)
  ) else $error("write-back and illegal pulse in the same cycle");

endmodule

`default_nettype wire

// File: exec_core.sv
// Integer execute core
`timescale 1ns/1ps
`default_nettype none

module exec_core (
  input  logic            clk,
  input  logic            reset,
  input  logic            instr_valid,
  input  mips_pkg::word_t instr,
  output mips_pkg::wb_t   wb,
  output logic            illegal,
  output mips_pkg::word_t reg_v0
);

  import mips_pkg::*;

  decoded_op_t decoded_op;
  logic        dec_illegal;
  word_t       rd1;
  word_t       rd2;
  wb_t         wr;

  // fields and immediate, purely combinational
  instr_decode u_decode (
    .instr_valid (instr_valid),
    .instr       (instr),
    .decoded_op  (decoded_op),
    .illegal     (dec_illegal)
  );

  // operands read in the strobe cycle, result written at its edge
  regfile u_regfile (
    .clk    (clk),
    .reset  (reset),
    .ra1    (decoded_op.rs),
    .ra2    (decoded_op.rt),
    .wr     (wr),
    .rd1    (rd1),
    .rd2    (rd2),
    .reg_v0 (reg_v0)
  );

  // wb and illegal leave one cycle after the strobe
  alu_writeback u_alu (
    .clk        (clk),
    .reset      (reset),
    .op         (decoded_op),
    .illegal_in (dec_illegal),
    .rd1        (rd1),
    .rd2        (rd2),
    .wr         (wr),
    .wb         (wb),
    .illegal    (illegal)
  );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic por_reset
);

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 4;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge
  initial begin
    por_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    por_reset = 1'b0;
  end

endmodule

`default_nettype wire

// File: tb_checker.sv
// Write-back checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic            clk,
  input  logic            reset,
  input  mips_pkg::wb_t   wb,
  input  logic            illegal,
  input  mips_pkg::word_t reg_v0
);

  import mips_pkg::*;

  // pending results, oldest first
  string     exp_name[$];
  logic      exp_illegal[$];
  reg_addr_t exp_addr[$];
  word_t     exp_data[$];
  int        exp_cycle[$];

  int cycles     = 0;
  int checks     = 0;
  int mismatches = 0;
  int other      = 0;

  task automatic expect_result(input string name, input logic is_illegal,
                               input reg_addr_t addr, input word_t data);
    exp_name.push_back(name);
    exp_illegal.push_back(is_illegal);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_cycle.push_back(cycles);
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    $display("MISMATCH %s %s: expected %h, actual %h", name, field, expected, actual);
    mismatches++;
  endtask

  // outputs are registered, so the value just before the edge is the settled one
  always @(posedge clk) begin : sample
    string     name;
    logic      e_illegal;
    reg_addr_t e_addr;
    word_t     e_data;
    int        issued;
    cycles = cycles + 1;
    if (!reset && (wb.valid || illegal)) begin
      if (exp_name.size() == 0) begin
        $display("ERROR: result pulse at %0t with no instruction pending", $time);
        other++;
      end else begin
        name      = exp_name.pop_front();
        e_illegal = exp_illegal.pop_front();
        e_addr    = exp_addr.pop_front();
        e_data    = exp_data.pop_front();
        issued    = exp_cycle.pop_front();
        checks++;
        // strobe edge comes one cycle after the push, the pulse one after that
        if (cycles - issued != 2) begin
          $display("ERROR: result of %s arrived %0d cycles after its strobe",
                   name, cycles - issued - 1);
          other++;
        end
        if (illegal !== e_illegal)
          report_mismatch(name, "illegal", 32'(e_illegal), 32'(illegal));
        if (e_illegal) begin
          if (wb.valid !== 1'b0)
            report_mismatch(name, "wb.valid", 32'h0, 32'(wb.valid));
        end else begin
          if (wb.addr !== e_addr)
            report_mismatch(name, "wb.addr", 32'(e_addr), 32'(wb.addr));
          if (wb.data !== e_data)
            report_mismatch(name, "wb.data", e_data, wb.data);
          if (e_addr == 5'd2 && reg_v0 !== e_data)
            report_mismatch(name, "reg_v0", e_data, reg_v0);
        end
      end
    end
  end

  task automatic close_report(output int total);
    if (exp_name.size() != 0) begin
      $display("ERROR: %0d results never arrived, first missing is %s",
               exp_name.size(), exp_name[0]);
      other += exp_name.size();
    end
    $display("checker: %0d results checked, %0d mismatches, %0d other errors",
             checks, mismatches, other);
    total = mismatches + other;
  endtask

endmodule

`default_nettype wire

// File: tb_exec_core.sv
// Execute core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;

  import mips_pkg::*;

  // row kinds
  localparam int K_WB      = 0;
  localparam int K_ILLEGAL = 1;
  localparam int K_NONE    = 2;
  localparam int K_RESET   = 3;

  localparam int CLK_PERIOD    = 100;
  localparam int RESET_NS      = 4 * CLK_PERIOD;
  localparam int MARGIN_CYCLES = 20;

  logic  clk;
  logic  por_reset;
  logic  mid_reset;
  logic  reset;
  logic  instr_valid;
  word_t instr;
  wb_t   wb;
  logic  illegal;
  word_t reg_v0;

  // stimulus table, one entry per index
  string     t_name[$];
  bit        t_chain[$];
  int        t_kind[$];
  word_t     t_instr[$];
  reg_addr_t t_addr[$];
  word_t     t_data[$];

  logic [31:0] lfsr;
  logic        table_ready;
  int          total_errors;

  assign reset = por_reset | mid_reset;

  tb_clock_gen u_clock_gen (
    .clk       (clk),
    .por_reset (por_reset)
  );

  exec_core u_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb          (wb),
    .illegal     (illegal),
    .reg_v0      (reg_v0)
  );

  tb_checker u_checker (
    .clk     (clk),
    .reset   (reset),
    .wb      (wb),
    .illegal (illegal),
    .reg_v0  (reg_v0)
  );

  function automatic word_t r_word(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t i_word(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                   logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Galois form, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic add_row(input string name, input bit chain, input int kind,
                         input word_t word, input reg_addr_t addr, input word_t data);
    t_name.push_back(name);
    t_chain.push_back(chain);
    t_kind.push_back(kind);
    t_instr.push_back(word);
    t_addr.push_back(addr);
    t_data.push_back(data);
  endtask

  // chained rows go straight after the previous strobe
  task automatic idle_gap(input bit chained);
    int gap;
    gap = 0;
    if (!chained) begin
      for (int b = 0; b < 2; b++) begin
        gap = gap | (int'(lfsr[0]) << b);
        lfsr = lfsr_step(lfsr);
      end
    end
    repeat (gap) begin
      instr_valid = 1'b0;
      @(negedge clk);
    end
  endtask

  task automatic build_table();
    // immediates
    add_row("lui_hi", 0, K_WB, i_word(OP_LUI, 0, 1, 16'h8000), 1, 32'h8000_0000);
    add_row("ori_chain", 1, K_WB, i_word(OP_ORI, 1, 1, 16'h0001), 1, 32'h8000_0001);
    add_row("addiu_neg", 0, K_WB, i_word(OP_ADDIU, 0, 3, 16'hfffb), 3, 32'hffff_fffb);
    add_row("ori_zext", 0, K_WB, i_word(OP_ORI, 0, 4, 16'h8001), 4, 32'h0000_8001);
    add_row("andi_zext", 0, K_WB, i_word(OP_ANDI, 3, 5, 16'hfff0), 5, 32'h0000_fff0);
    add_row("slti_true", 0, K_WB, i_word(OP_SLTI, 3, 6, 16'h0001), 6, 32'h1);
    add_row("slti_false", 0, K_WB, i_word(OP_SLTI, 4, 7, 16'hffff), 7, 32'h0);
    add_row("xori", 0, K_WB, i_word(OP_XORI, 4, 8, 16'hffff), 8, 32'h0000_7ffe);
    add_row("addiu_v0", 0, K_WB, i_word(OP_ADDIU, 0, 2, 16'h1234), 2, 32'h0000_1234);
    add_row("lui_max", 0, K_WB, i_word(OP_LUI, 0, 9, 16'h7fff), 9, 32'h7fff_0000);
    add_row("ori_max", 1, K_WB, i_word(OP_ORI, 9, 9, 16'hffff), 9, 32'h7fff_ffff);
    // register operands
    add_row("addu_wrap", 0, K_WB, r_word(FN_ADDU, 1, 1, 10), 10, 32'h0000_0002);
    add_row("subu", 0, K_WB, r_word(FN_SUBU, 4, 3, 11), 11, 32'h0000_8006);
    add_row("and", 0, K_WB, r_word(FN_AND, 1, 9, 12), 12, 32'h0000_0001);
    add_row("or", 0, K_WB, r_word(FN_OR, 1, 4, 13), 13, 32'h8000_8001);
    add_row("xor", 0, K_WB, r_word(FN_XOR, 1, 3, 14), 14, 32'h7fff_fffa);
    add_row("nor", 0, K_WB, r_word(FN_NOR, 4, 9, 15), 15, 32'h8000_0000);
    add_row("slt_neg_pos", 0, K_WB, r_word(FN_SLT, 1, 9, 16), 16, 32'h1);
    add_row("sltu_neg_pos", 0, K_WB, r_word(FN_SLTU, 1, 9, 17), 17, 32'h0);
    add_row("slt_pos_neg", 0, K_WB, r_word(FN_SLT, 9, 1, 18), 18, 32'h0);
    add_row("sltu_pos_neg", 0, K_WB, r_word(FN_SLTU, 9, 1, 19), 19, 32'h1);
    // back-to-back dependencies
    add_row("dep_first", 0, K_WB, r_word(FN_ADDU, 12, 11, 2), 2, 32'h0000_8007);
    add_row("dep_second", 1, K_WB, r_word(FN_SUBU, 2, 6, 2), 2, 32'h0000_8006);
    add_row("dep_third", 1, K_WB, r_word(FN_ADDU, 2, 2, 20), 20, 32'h0001_000c);
    // writes to $zero are dropped
    add_row("addiu_r0", 0, K_NONE, i_word(OP_ADDIU, 3, 0, 16'h0007), 0, 0);
    add_row("addu_r0", 1, K_NONE, r_word(FN_ADDU, 1, 1, 0), 0, 0);
    add_row("or_from_r0", 1, K_WB, r_word(FN_OR, 0, 4, 21), 21, 32'h0000_8001);
    add_row("subu_from_r0", 0, K_WB, r_word(FN_SUBU, 0, 6, 22), 22, 32'hffff_ffff);
    add_row("lui_r0", 0, K_NONE, i_word(OP_LUI, 0, 0, 16'hdead), 0, 0);
    add_row("addiu_v0_low", 0, K_WB, i_word(OP_ADDIU, 0, 2, 16'h0055), 2, 32'h0000_0055);
    // rejected words leave their target alone
    add_row("lw_illegal", 0, K_ILLEGAL, i_word(6'h23, 1, 2, 16'h0000), 0, 0);
    add_row("v0_kept", 1, K_WB, r_word(FN_ADDU, 2, 0, 23), 23, 32'h0000_0055);
    add_row("sll_illegal", 0, K_ILLEGAL, r_word(6'h00, 1, 1, 9), 0, 0);
    add_row("r9_kept", 1, K_WB, r_word(FN_OR, 9, 0, 24), 24, 32'h7fff_ffff);
    add_row("addi_illegal", 0, K_ILLEGAL, i_word(6'h08, 0, 4, 16'h1111), 0, 0);
    add_row("r4_kept", 1, K_WB, i_word(OP_ADDIU, 4, 25, 16'h0000), 25, 32'h0000_8001);
    // second reset clears the whole array
    add_row("mid_reset", 0, K_RESET, '0, 0, 0);
    add_row("r1_r9_clear", 0, K_WB, r_word(FN_ADDU, 1, 9, 26), 26, 32'h0);
    add_row("v0_clear", 0, K_WB, r_word(FN_OR, 3, 4, 2), 2, 32'h0);
    add_row("ori_clear", 0, K_WB, i_word(OP_ORI, 13, 27, 16'h0000), 27, 32'h0);
    add_row("lui_after", 0, K_WB, i_word(OP_LUI, 0, 28, 16'h0001), 28, 32'h0001_0000);
    add_row("addu_after", 1, K_WB, r_word(FN_ADDU, 28, 28, 29), 29, 32'h0002_0000);
  endtask

  initial begin : drive
    instr_valid = 1'b0;
    instr       = '0;
    mid_reset   = 1'b0;
    lfsr        = 32'h9b14;
    build_table();
    table_ready = 1'b1;
    @(negedge por_reset);
    for (int i = 0; i < t_name.size(); i++) begin
      idle_gap(t_chain[i]);
      if (t_kind[i] == K_RESET) begin
        // let the last result drain before reset
        instr_valid = 1'b0;
        @(negedge clk);
        mid_reset = 1'b1;
        repeat (2) @(negedge clk);
        mid_reset = 1'b0;
      end else begin
        instr_valid = 1'b1;
        instr       = t_instr[i];
        if (t_kind[i] != K_NONE)
          u_checker.expect_result(t_name[i], t_kind[i] == K_ILLEGAL, t_addr[i], t_data[i]);
        @(negedge clk);
      end
    end
    instr_valid = 1'b0;
    repeat (3) @(negedge clk);
    u_checker.close_report(total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // worst case per row is a 3 cycle gap plus the strobe
  initial begin : watchdog
    int limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = (t_name.size() * 5 + MARGIN_CYCLES) * CLK_PERIOD + RESET_NS;
    #(limit_ns);
    $display("ERROR: watchdog expired after %0d ns, the run did not finish", limit_ns);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
mips_pkg.sv
instr_decode.sv
regfile.sv
alu_writeback.sv
exec_core.sv
tb_clock_gen.sv
tb_checker.sv
tb_exec_core.sv
